// ==== core_pkg.sv ====
package core_pkg;

    // Datapath widths
    localparam int XLEN           = 32;
    localparam int NUM_REGS       = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int FTQ_ID_W       = 3;
    localparam int NUM_LANES      = 2;
    localparam int NUM_READ_PORTS = 4;
    localparam int BYTE_SEL_W     = 4;
    localparam int DEBUG_WEN_W    = 4;

    // Branch result of one execute lane
    typedef struct packed {
        logic                flag;
        logic [XLEN-1:0]     target;
        logic [FTQ_ID_W-1:0] ftq_id;
    } branch_req_t;

    // Events raised at commit that redirect the frontend
    typedef struct packed {
        logic                                excp_flush;
        logic                                tlbrefill;
        logic                                ertn_flush;
        logic                                idle_flush;
        logic [XLEN-1:0]                     eentry;
        logic [XLEN-1:0]                     tlbrentry;
        logic [XLEN-1:0]                     era;
        logic [XLEN-1:0]                     idle_pc;
        logic [NUM_LANES-1:0][FTQ_ID_W-1:0]  wb_ftq_id;
    } trap_req_t;

    // One memory request toward the data cache
    typedef struct packed {
        logic                  ce;
        logic                  we;
        logic [BYTE_SEL_W-1:0] sel;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       data;
    } mem_req_t;

    // Register write of one lane at write-back
    typedef struct packed {
        logic                  we;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } wb_write_t;

    // Debug trace record, same layout as the debug_wb ports of the core
    typedef struct packed {
        logic [XLEN-1:0]        pc;
        logic [DEBUG_WEN_W-1:0] wen;
        logic [REG_ADDR_W-1:0]  wnum;
        logic [XLEN-1:0]        wdata;
    } debug_commit_t;

    typedef enum logic [2:0] {
        SRC_NONE      = 3'd0,
        SRC_EXCP      = 3'd1,
        SRC_TLBREFILL = 3'd2,
        SRC_ERTN      = 3'd3,
        SRC_IDLE      = 3'd4,
        SRC_BRANCH0   = 3'd5,
        SRC_BRANCH1   = 3'd6
    } redirect_src_e;

endpackage

// ==== redirect_ctrl.sv ====
module redirect_ctrl (
    input  core_pkg::trap_req_t                               trap_i,
    input  core_pkg::branch_req_t [core_pkg::NUM_LANES-1:0]   branch_i,
    input  logic                                              ex_stall_i,
    output core_pkg::redirect_src_e                           src_o,
    output logic                                              flush_o
);

    logic branch0_ok;
    logic branch1_ok;

    // A stalled execute stage may still hold a stale branch result,
    // so branches only redirect once the stage moves on
    assign branch0_ok = branch_i[0].flag & ~ex_stall_i;
    assign branch1_ok = branch_i[1].flag & ~ex_stall_i;

    // Exception first, then ertn, idle and the two lanes in order
    always_comb begin
        src_o = core_pkg::SRC_NONE;
        if (trap_i.excp_flush) begin
            if (trap_i.tlbrefill) begin
                src_o = core_pkg::SRC_TLBREFILL;
            end else begin
                src_o = core_pkg::SRC_EXCP;
            end
        end else if (trap_i.ertn_flush) begin
            src_o = core_pkg::SRC_ERTN;
        end else if (trap_i.idle_flush) begin
            src_o = core_pkg::SRC_IDLE;
        end else if (branch0_ok) begin
            src_o = core_pkg::SRC_BRANCH0;
        end else if (branch1_ok) begin
            src_o = core_pkg::SRC_BRANCH1;
        end
    end

    assign flush_o = trap_i.excp_flush | trap_i.ertn_flush | trap_i.idle_flush |
                     branch0_ok | branch1_ok;

endmodule

// ==== redirect_target.sv ====
module redirect_target (
    input  core_pkg::redirect_src_e                           src_i,
    input  core_pkg::trap_req_t                               trap_i,
    input  core_pkg::branch_req_t [core_pkg::NUM_LANES-1:0]   branch_i,
    output logic [core_pkg::XLEN-1:0]                         next_pc_o,
    output logic [core_pkg::FTQ_ID_W-1:0]                     flush_ftq_id_o
);

    logic [core_pkg::FTQ_ID_W-1:0] wb_ftq_id;

    // Only the committing lane carries a non-zero id
    assign wb_ftq_id = trap_i.wb_ftq_id[0] | trap_i.wb_ftq_id[1];

    always_comb begin
        next_pc_o      = '0;
        flush_ftq_id_o = '0;
        case (src_i)
            core_pkg::SRC_EXCP: begin
                next_pc_o      = trap_i.eentry;
                flush_ftq_id_o = wb_ftq_id;
            end
            core_pkg::SRC_TLBREFILL: begin
                next_pc_o      = trap_i.tlbrentry;
                flush_ftq_id_o = wb_ftq_id;
            end
            core_pkg::SRC_ERTN: begin
                next_pc_o      = trap_i.era;
                flush_ftq_id_o = wb_ftq_id;
            end
            core_pkg::SRC_IDLE: begin
                next_pc_o      = trap_i.idle_pc;
                flush_ftq_id_o = wb_ftq_id;
            end
            core_pkg::SRC_BRANCH0: begin
                next_pc_o      = branch_i[0].target;
                flush_ftq_id_o = branch_i[0].ftq_id;
            end
            core_pkg::SRC_BRANCH1: begin
                next_pc_o      = branch_i[1].target;
                flush_ftq_id_o = branch_i[1].ftq_id;
            end
            default: begin
                next_pc_o      = '0;
                flush_ftq_id_o = '0;
            end
        endcase
    end

endmodule

// ==== mem_port_merge.sv ====
module mem_port_merge (
    input  core_pkg::mem_req_t [core_pkg::NUM_LANES-1:0] lane_req_i,
    output core_pkg::mem_req_t                           cache_req_o
);

    // At most one lane issues an address in a cycle, the other holds zero
    assign cache_req_o.ce   = lane_req_i[0].ce | lane_req_i[1].ce;
    assign cache_req_o.we   = lane_req_i[0].we | lane_req_i[1].we;
    assign cache_req_o.addr = lane_req_i[0].addr | lane_req_i[1].addr;

    // Store payload follows the writing lane, lane 0 first
    always_comb begin
        if (lane_req_i[0].we) begin
            cache_req_o.sel  = lane_req_i[0].sel;
            cache_req_o.data = lane_req_i[0].data;
        end else if (lane_req_i[1].we) begin
            cache_req_o.sel  = lane_req_i[1].sel;
            cache_req_o.data = lane_req_i[1].data;
        end else begin
            cache_req_o.sel  = '0;
            cache_req_o.data = '0;
        end
    end

endmodule

// ==== gpr_file.sv ====
module gpr_file (
    input  logic                                                         clk,
    input  logic                                                         rst_i,
    input  core_pkg::wb_write_t [core_pkg::NUM_LANES-1:0]                wb_i,
    input  logic [core_pkg::NUM_READ_PORTS-1:0][core_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [core_pkg::NUM_READ_PORTS-1:0][core_pkg::XLEN-1:0]       rdata_o
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

    // Lane 1 is applied last so it wins a same-register conflict
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < core_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
                if (wb_i[l].we && (wb_i[l].waddr != '0)) begin
                    regs[wb_i[l].waddr] <= wb_i[l].wdata;
                end
            end
        end
    end

    // No bypass from the write lanes
    always_comb begin
        for (int p = 0; p < core_pkg::NUM_READ_PORTS; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

// ==== commit_trace.sv ====
module commit_trace (
    input  logic                                              clk,
    input  logic                                              rst_i,
    input  core_pkg::wb_write_t [core_pkg::NUM_LANES-1:0]     wb_i,
    output core_pkg::debug_commit_t [core_pkg::NUM_LANES-1:0] debug_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            debug_o <= '0;
        end else begin
            for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
                debug_o[l].pc    <= wb_i[l].pc;
                // Single enable bit widened to the byte-wen field
                debug_o[l].wen   <= {{(core_pkg::DEBUG_WEN_W-1){1'b0}}, wb_i[l].we};
                debug_o[l].wnum  <= wb_i[l].waddr;
                debug_o[l].wdata <= wb_i[l].wdata;
            end
        end
    end

endmodule

// ==== backend_top.sv ====
module backend_top (
    input  logic                                                          clk,
    input  logic                                                          rst_i,

    // Redirect events
    input  core_pkg::trap_req_t                                           trap_i,
    input  core_pkg::branch_req_t [core_pkg::NUM_LANES-1:0]               branch_i,
    input  logic                                                          ex_stall_i,

    // Memory requests from the two lanes
    input  core_pkg::mem_req_t [core_pkg::NUM_LANES-1:0]                  lane_req_i,

    // Write-back and register reads
    input  core_pkg::wb_write_t [core_pkg::NUM_LANES-1:0]                 wb_i,
    input  logic [core_pkg::NUM_READ_PORTS-1:0][core_pkg::REG_ADDR_W-1:0] raddr_i,

    // Frontend redirect
    output logic                                                          flush_o,
    output logic [core_pkg::XLEN-1:0]                                     next_pc_o,
    output logic [core_pkg::FTQ_ID_W-1:0]                                 flush_ftq_id_o,

    output core_pkg::mem_req_t                                            cache_req_o,
    output logic [core_pkg::NUM_READ_PORTS-1:0][core_pkg::XLEN-1:0]       rdata_o,
    output core_pkg::debug_commit_t [core_pkg::NUM_LANES-1:0]             debug_o
);

    core_pkg::redirect_src_e redirect_src;

    redirect_ctrl u_redirect_ctrl (
        .trap_i    (trap_i),
        .branch_i  (branch_i),
        .ex_stall_i(ex_stall_i),
        .src_o     (redirect_src),
        .flush_o   (flush_o)
    );

    redirect_target u_redirect_target (
        .src_i         (redirect_src),
        .trap_i        (trap_i),
        .branch_i      (branch_i),
        .next_pc_o     (next_pc_o),
        .flush_ftq_id_o(flush_ftq_id_o)
    );

    // Merged request leaves the core directly
    mem_port_merge u_mem_port_merge (
        .lane_req_i (lane_req_i),
        .cache_req_o(cache_req_o)
    );

    gpr_file u_gpr_file (
        .clk    (clk),
        .rst_i  (rst_i),
        .wb_i   (wb_i),
        .raddr_i(raddr_i),
        .rdata_o(rdata_o)
    );

    commit_trace u_commit_trace (
        .clk    (clk),
        .rst_i  (rst_i),
        .wb_i   (wb_i),
        .debug_o(debug_o)
    );

endmodule

// ==== tb_clock.sv ====
module tb_clock (
    output logic clk_o
);

    // 20 time unit period
    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

endmodule

// ==== backend_props.sv ====
module backend_props (
    input logic                                              clk,
    input logic                                              rst_i,
    input core_pkg::trap_req_t                               trap_i,
    input logic                                              flush_o,
    input logic [core_pkg::XLEN-1:0]                         next_pc_o,
    input core_pkg::debug_commit_t [core_pkg::NUM_LANES-1:0] debug_o
);

    // Any trap event must redirect the frontend
    trap_flushes: assert property (@(posedge clk) disable iff (rst_i)
        (trap_i.excp_flush | trap_i.ertn_flush | trap_i.idle_flush) |-> flush_o)
        else $error("trap event without flush");

    // No redirect means no target
    idle_pc_zero: assert property (@(posedge clk) disable iff (rst_i)
        !flush_o |-> (next_pc_o == '0))
        else $error("next_pc_o not zero without flush");

    // Trace still holds its reset value right after reset
    trace_clear: assert property (@(posedge clk)
        $fell(rst_i) |-> ((debug_o[0].wen == '0) && (debug_o[1].wen == '0)))
        else $error("debug wen not zero after reset");

endmodule

bind backend_top backend_props u_props (.*);

// ==== tb_backend.sv ====
module tb_backend;

    typedef struct {
        logic excp, tlb, ertn, idle, b0, b1, stall;
        logic exp_flush;
        core_pkg::redirect_src_e exp_src;
    } redir_row_t;

    typedef struct {
        logic ce0, we0, ce1, we1;
        logic exp_ce, exp_we;
        int   payload_lane;
    } merge_row_t;

    typedef struct {
        logic we0;
        logic [4:0] addr0;
        logic we1;
        logic [4:0] addr1;
    } write_row_t;

    localparam logic [31:0] EENTRY    = 32'h1c00_8000;
    localparam logic [31:0] TLBRENTRY = 32'h1c00_f000;
    localparam logic [31:0] ERA       = 32'h1c00_1234;
    localparam logic [31:0] IDLE_PC   = 32'h1c00_2000;
    localparam logic [31:0] BR0_PC    = 32'h1c00_3000;
    localparam logic [31:0] BR1_PC    = 32'h1c00_4000;

    // Rows 0..7 cover priority, rows 8..10 run with ex_stall high
    redir_row_t redir_rows [11] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0, core_pkg::SRC_NONE},
        '{0, 0, 0, 0, 0, 1, 0, 1, core_pkg::SRC_BRANCH1},
        '{0, 0, 0, 0, 1, 1, 0, 1, core_pkg::SRC_BRANCH0},
        '{0, 0, 0, 1, 1, 0, 0, 1, core_pkg::SRC_IDLE},
        '{0, 0, 1, 1, 1, 0, 0, 1, core_pkg::SRC_ERTN},
        '{1, 0, 1, 0, 0, 0, 0, 1, core_pkg::SRC_EXCP},
        '{1, 1, 1, 0, 0, 1, 0, 1, core_pkg::SRC_TLBREFILL},
        '{0, 1, 0, 0, 0, 0, 0, 0, core_pkg::SRC_NONE},
        '{0, 0, 0, 0, 1, 1, 1, 0, core_pkg::SRC_NONE},
        '{0, 0, 0, 1, 1, 0, 1, 1, core_pkg::SRC_IDLE},
        '{1, 0, 0, 0, 0, 1, 1, 1, core_pkg::SRC_EXCP}
    };

    merge_row_t merge_rows [5] = '{
        '{1, 1, 0, 0, 1, 1, 0},
        '{0, 0, 1, 1, 1, 1, 1},
        '{1, 1, 1, 1, 1, 1, 0},
        '{1, 0, 0, 0, 1, 0, 2},
        '{1, 0, 1, 0, 1, 0, 2}
    };

    // Includes a same-register conflict and a write to register 0
    write_row_t write_rows [5] = '{
        '{1, 5'd1, 1, 5'd2},
        '{1, 5'd5, 1, 5'd5},
        '{1, 5'd0, 1, 5'd3},
        '{1, 5'd7, 0, 5'd8},
        '{0, 5'd9, 1, 5'd31}
    };

    logic clk;
    logic rst_i;
    core_pkg::trap_req_t trap;
    core_pkg::branch_req_t [1:0] branch;
    logic ex_stall;
    core_pkg::mem_req_t [1:0] lane_req;
    core_pkg::wb_write_t [1:0] wb;
    logic [3:0][4:0] raddr;
    logic flush;
    logic [31:0] next_pc;
    logic [2:0] flush_ftq_id;
    core_pkg::mem_req_t cache_req;
    logic [3:0][31:0] rdata;
    core_pkg::debug_commit_t [1:0] debug;

    logic [31:0] lcg_state = 32'd38015;
    logic [31:0] shadow [32];
    int checks = 0;
    int errors = 0;

    tb_clock u_clock (.clk_o(clk));

    backend_top dut_i (
        .clk(clk), .rst_i(rst_i), .trap_i(trap), .branch_i(branch),
        .ex_stall_i(ex_stall), .lane_req_i(lane_req), .wb_i(wb), .raddr_i(raddr),
        .flush_o(flush), .next_pc_o(next_pc), .flush_ftq_id_o(flush_ftq_id),
        .cache_req_o(cache_req), .rdata_o(rdata), .debug_o(debug)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic compare_value(input string what, input logic [95:0] got,
                                 input logic [95:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("** Error [%0t] %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Next rising edge plus the drive delay, bounded
    task automatic next_cycle();
        int guard;
        guard = 0;
        while (clk !== 1'b0 && guard < 100) begin
            #1 guard++;
        end
        while (clk !== 1'b1 && guard < 100) begin
            #1 guard++;
        end
        if (guard >= 100) begin
            $display("Clock stopped toggling");
            $display("** FAIL **");
            $finish;
        end else begin
            #2;
        end
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic run_redirect(input int first, input int last, input string name);
        int e0;
        logic [31:0] exp_pc;
        logic [2:0] exp_id;
        e0 = errors;
        for (int i = first; i <= last; i++) begin
            trap.excp_flush = redir_rows[i].excp;
            trap.tlbrefill  = redir_rows[i].tlb;
            trap.ertn_flush = redir_rows[i].ertn;
            trap.idle_flush = redir_rows[i].idle;
            branch[0].flag  = redir_rows[i].b0;
            branch[1].flag  = redir_rows[i].b1;
            ex_stall        = redir_rows[i].stall;
            exp_pc = '0;
            exp_id = 3'd3 | 3'd6;
            case (redir_rows[i].exp_src)
                core_pkg::SRC_EXCP:      exp_pc = EENTRY;
                core_pkg::SRC_TLBREFILL: exp_pc = TLBRENTRY;
                core_pkg::SRC_ERTN:      exp_pc = ERA;
                core_pkg::SRC_IDLE:      exp_pc = IDLE_PC;
                core_pkg::SRC_BRANCH0: begin
                    exp_pc = BR0_PC;
                    exp_id = 3'd1;
                end
                core_pkg::SRC_BRANCH1: begin
                    exp_pc = BR1_PC;
                    exp_id = 3'd5;
                end
                default: exp_id = '0;
            endcase
            #5;
            compare_value($sformatf("row %0d flush", i), 96'(flush),
                          96'(redir_rows[i].exp_flush));
            compare_value($sformatf("row %0d next_pc", i), 96'(next_pc), 96'(exp_pc));
            compare_value($sformatf("row %0d ftq_id", i), 96'(flush_ftq_id), 96'(exp_id));
            next_cycle();
        end
        trap.excp_flush = 0;
        trap.tlbrefill  = 0;
        trap.ertn_flush = 0;
        trap.idle_flush = 0;
        branch[0].flag  = 0;
        branch[1].flag  = 0;
        ex_stall        = 0;
        report(name, e0);
    endtask

    initial begin
        #200000;
        $display("Timeout: simulation did not finish");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int e0;
        logic [31:0] exp_addr;
        core_pkg::wb_write_t [1:0] prev;
        core_pkg::debug_commit_t exp_rec;
        rst_i = 1'b1;
        trap = '0;
        branch = '0;
        ex_stall = 1'b0;
        lane_req = '0;
        wb = '0;
        raddr = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        trap.eentry = EENTRY;
        trap.tlbrentry = TLBRENTRY;
        trap.era = ERA;
        trap.idle_pc = IDLE_PC;
        // Overlapping bits so OR differs from XOR and sum
        trap.wb_ftq_id[0] = 3'd3;
        trap.wb_ftq_id[1] = 3'd6;
        branch[0].target = BR0_PC;
        branch[0].ftq_id = 3'd1;
        branch[1].target = BR1_PC;
        branch[1].ftq_id = 3'd5;
        for (int c = 0; c < 4; c++) begin
            next_cycle();
        end
        rst_i = 1'b0;

        e0 = errors;
        raddr = {5'd31, 5'd17, 5'd4, 5'd1};
        #5;
        for (int p = 0; p < 4; p++) begin
            compare_value($sformatf("reset read port %0d", p), 96'(rdata[p]), '0);
        end
        for (int l = 0; l < 2; l++) begin
            compare_value($sformatf("reset debug lane %0d", l), 96'(debug[l]), '0);
        end
        compare_value("reset flush", 96'(flush), '0);
        report("reset", e0);
        next_cycle();

        run_redirect(0, 7, "redirect priority");
        run_redirect(8, 10, "branch gating");

        e0 = errors;
        foreach (merge_rows[i]) begin
            lane_req[0] = '{merge_rows[i].ce0, merge_rows[i].we0, 4'hf,
                            merge_rows[i].ce0 ? 32'h0000_1000 : 32'h0, next_rand()};
            lane_req[1] = '{merge_rows[i].ce1, merge_rows[i].we1, 4'h3,
                            merge_rows[i].ce1 ? 32'h0000_2004 : 32'h0, next_rand()};
            exp_addr = lane_req[0].addr | lane_req[1].addr;
            #5;
            compare_value($sformatf("merge %0d ce", i), 96'(cache_req.ce),
                          96'(merge_rows[i].exp_ce));
            compare_value($sformatf("merge %0d we", i), 96'(cache_req.we),
                          96'(merge_rows[i].exp_we));
            compare_value($sformatf("merge %0d addr", i), 96'(cache_req.addr),
                          96'(exp_addr));
            if (merge_rows[i].payload_lane < 2) begin
                compare_value($sformatf("merge %0d sel", i), 96'(cache_req.sel),
                              96'(lane_req[merge_rows[i].payload_lane].sel));
                compare_value($sformatf("merge %0d data", i), 96'(cache_req.data),
                              96'(lane_req[merge_rows[i].payload_lane].data));
            end else begin
                compare_value($sformatf("merge %0d sel", i), 96'(cache_req.sel), '0);
                compare_value($sformatf("merge %0d data", i), 96'(cache_req.data), '0);
            end
            next_cycle();
        end
        lane_req = '0;
        report("memory merge", e0);

        e0 = errors;
        foreach (write_rows[i]) begin
            wb[0] = '{write_rows[i].we0, 32'h1c00_0100 + 8 * i, write_rows[i].addr0, next_rand()};
            wb[1] = '{write_rows[i].we1, 32'h1c00_0104 + 8 * i, write_rows[i].addr1, next_rand()};
            prev = wb;
            next_cycle();
            // Lane 1 applied last, register 0 stays zero
            for (int l = 0; l < 2; l++) begin
                if (prev[l].we && prev[l].waddr != 0) begin
                    shadow[prev[l].waddr] = prev[l].wdata;
                end
            end
            wb = '0;
            // Port order alternates so every port reads a written register
            if (i % 2 == 0) begin
                raddr = {5'd0, write_rows[i].addr1, write_rows[i].addr0, 5'd5};
            end else begin
                raddr = {write_rows[i].addr0, 5'd5, 5'd0, write_rows[i].addr1};
            end
            #5;
            for (int p = 0; p < 4; p++) begin
                compare_value($sformatf("write %0d read port %0d", i, p), 96'(rdata[p]),
                              96'(shadow[raddr[p]]));
            end
            for (int l = 0; l < 2; l++) begin
                exp_rec = '{prev[l].pc, {3'b000, prev[l].we}, prev[l].waddr, prev[l].wdata};
                compare_value($sformatf("write %0d trace lane %0d", i, l), 96'(debug[l]),
                              96'(exp_rec));
            end
            next_cycle();
        end
        report("register file and trace", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
core_pkg.sv
redirect_ctrl.sv
redirect_target.sv
mem_port_merge.sv
gpr_file.sv
commit_trace.sv
backend_top.sv
tb_clock.sv
backend_props.sv
tb_backend.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_backend
FILELIST  = compile.f
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
